// File: common/btb_cfg.svh
`ifndef BTB_CFG_SVH
`define BTB_CFG_SVH

// **************************************************
// Geometry of the branch target buffer.
// **************************************************

// Byte offset bits below the set index.
`define BTB_S_OFFSET 2

// Set index bits, 8 sets.
`define BTB_S_INDEX 3

// Fetch PC and target width.
`define BTB_PC_WIDTH 32

// Tag width follows from the three above.

`endif

// File: common/btb_addr_pkg.sv
`default_nettype none

`include "btb_cfg.svh"

package btb_addr_pkg;

    typedef logic [`BTB_PC_WIDTH-1:0] pc_t;    // Fetch PC.
    typedef logic [`BTB_S_INDEX-1:0]  index_t; // Set select.
    typedef logic [`BTB_PC_WIDTH-`BTB_S_INDEX-`BTB_S_OFFSET-1:0] tag_t; // Upper PC bits.

    // Set index field of a fetch PC.
    function automatic index_t pc_index(input pc_t pc);
        return pc[`BTB_S_OFFSET +: `BTB_S_INDEX];    // Bits just above the offset.
    endfunction

    // Tag field of a fetch PC.
    function automatic tag_t pc_tag(input pc_t pc);
        return pc[`BTB_PC_WIDTH-1 -: $bits(tag_t)];  // Everything above the index.
    endfunction

endpackage

`default_nettype wire

// File: common/btb_entry_pkg.sv
`default_nettype none

`include "btb_cfg.svh"

package btb_entry_pkg;

    // Predicted branch target, full PC width.
    typedef logic [`BTB_PC_WIDTH-1:0] target_t;

    // Way number, 1 bit for two ways.
    // Also the type of the per-set LRU bit.
    typedef logic way_t;

endpackage

`default_nettype wire

// File: common/btb_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface btb_ctrl_if;

    logic set_valid;    // Mark the chosen way valid.
    logic load_tag;     // Write the tag of the chosen way.
    logic load_data;    // Write the target of the chosen way.
    logic set_lru;      // Point the LRU away from the chosen way.
    logic hit;          // Tag match in either valid way.

    // Controller side.
    modport ctrl (
        output set_valid,
        output load_tag,
        output load_data,
        output set_lru,
        input  hit
    );

    // Datapath side.
    modport dp (
        input  set_valid,
        input  load_tag,
        input  load_data,
        input  set_lru,
        output hit
    );

endinterface

`default_nettype wire

// File: hw/btb_control.sv
`timescale 1ns/1ps
`default_nettype none

module btb_control (
    input  logic mem_read,    // Lookup strobe.
    input  logic mem_write,   // Update strobe.
    btb_ctrl_if.ctrl ctrl     // Array strobes out, hit back.
);

    logic set_valid;          // Decoded strobes.
    logic load_tag;
    logic load_data;
    logic set_lru;

    // **************************************************
    // Request decode, no state and no latency.
    // **************************************************
    always_comb begin : strobe_decode
        // All strobes idle.
        set_valid = 1'b0;
        load_tag  = 1'b0;
        load_data = 1'b0;
        set_lru   = 1'b0;
        unique case ({mem_write, mem_read})
            2'b00: ;                          // Idle.
            2'b01: set_lru = ctrl.hit;        // Missed lookup leaves LRU alone.
            2'b10: begin                      // Update only.
                set_valid = 1'b1;
                load_tag  = 1'b1;
                load_data = 1'b1;
                set_lru   = 1'b1;
            end
            2'b11: begin                      // Write wins, lookup sees old data.
                set_valid = 1'b1;
                load_tag  = 1'b1;
                load_data = 1'b1;
                set_lru   = 1'b1;
            end
            default: ;
        endcase
    end

    assign ctrl.set_valid = set_valid;
    assign ctrl.load_tag  = load_tag;
    assign ctrl.load_data = load_data;
    assign ctrl.set_lru   = set_lru;

endmodule

`default_nettype wire

// File: hw/btb_datapath/btb_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module btb_datapath (
    input  logic                   clk,
    input  logic                   rst_n,
    input  btb_addr_pkg::pc_t      pc,           // Lookup and update address.
    input  btb_entry_pkg::target_t wr_target,    // Resolved target to store.
    input  logic                   mem_read,     // Loads the response register.
    btb_ctrl_if.dp                 dp,           // Strobes in, hit out.
    output logic                   resp_valid,   // Read answered.
    output logic                   resp_hit,     // Read found an entry.
    output btb_entry_pkg::target_t resp_target   // Predicted target.
);

    import btb_addr_pkg::*;
    import btb_entry_pkg::*;

    localparam int NUM_SETS = 2 ** $bits(index_t);    // Sets in each way.
    localparam int NUM_WAYS = 2 ** $bits(way_t);      // Two ways.

    // **************************************************
    // Storage.
    // **************************************************
    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];            // Valid per set, one bit per way.
    way_t                lru_q   [NUM_SETS];            // Least recently used way.
    tag_t                tag_q    [NUM_WAYS][NUM_SETS]; // Stored tags.
    target_t             target_q [NUM_WAYS][NUM_SETS]; // Stored targets.

    // **************************************************
    // Lookup.
    // **************************************************
    index_t              idx;        // Set of the current PC.
    tag_t                cur_tag;    // Tag of the current PC.
    logic [NUM_WAYS-1:0] way_hit;    // Per way match.
    way_t                hit_way;    // Matching way.
    way_t                use_way;    // Way touched by this request.
    target_t             rd_target;  // Target of the matching way.

    assign idx     = pc_index(pc);
    assign cur_tag = pc_tag(pc);

    always_comb begin : tag_compare
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid_q[idx][w] && (tag_q[w][idx] == cur_tag);  // Valid and equal.
        end
    end

    assign dp.hit  = |way_hit;                  // Either way matches.
    assign hit_way = way_t'(way_hit[1]);        // Way 1 or else way 0.

    // Hit way if present, LRU way otherwise.
    assign use_way = dp.hit ? hit_way : lru_q[idx];

    assign rd_target = target_q[hit_way][idx];  // Meaningful only on hit.

    // **************************************************
    // Array updates.
    // **************************************************

    // Valid bits and LRU clear on reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;      // Empty buffer.
                lru_q[s]   <= '0;      // Way 0 replaced first.
            end
        end else begin
            if (dp.set_valid) begin
                valid_q[idx][use_way] <= 1'b1;
            end
            if (dp.set_lru) begin
                lru_q[idx] <= ~use_way;   // Point at the other way.
            end
        end
    end

    // Tag and target payload.
    always_ff @(posedge clk) begin
        if (dp.load_tag) begin
            tag_q[use_way][idx] <= cur_tag;
        end
        if (dp.load_data) begin
            target_q[use_way][idx] <= wr_target;
        end
    end

    // **************************************************
    // Response register, one cycle after the read.
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
            resp_hit   <= 1'b0;
        end else begin
            resp_valid <= mem_read;             // One cycle pulse per read.
            resp_hit   <= mem_read & dp.hit;    // Only with a valid response.
        end
    end

    always_ff @(posedge clk) begin
        if (mem_read) begin
            resp_target <= dp.hit ? rd_target : '0;  // Zero on a miss.
        end
    end

endmodule

`default_nettype wire

// File: hw/btb_top.sv
`timescale 1ns/1ps
`default_nettype none

module btb_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mem_read,     // Lookup strobe.
    input  logic                   mem_write,    // Update strobe.
    input  btb_addr_pkg::pc_t      pc,           // Fetch or branch PC.
    input  btb_entry_pkg::target_t wr_target,    // Resolved target.
    output logic                   resp_valid,   // Lookup answered.
    output logic                   resp_hit,     // Lookup found an entry.
    output btb_entry_pkg::target_t resp_target   // Predicted target.
);

    // **************************************************
    // Strobes between controller and arrays.
    // **************************************************
    btb_ctrl_if ctrl_if ();

    // Request decode.
    btb_control u_control (
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .ctrl      (ctrl_if.ctrl)
    );

    // Arrays, compare and response.
    btb_datapath u_datapath (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc          (pc),
        .wr_target   (wr_target),
        .mem_read    (mem_read),
        .dp          (ctrl_if.dp),
        .resp_valid  (resp_valid),
        .resp_hit    (resp_hit),
        .resp_target (resp_target)
    );

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter realtime PERIOD = 4.0    // Clock period in ns.
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;                  // Held over two rising edges.
        #(2 * PERIOD) rst_n = 1'b1;    // Released on a falling edge.
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: test/btb_assert.sv
`timescale 1ns/1ps
`default_nettype none

module btb_assert (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   mem_read,
    input logic                   resp_valid,
    input logic                   resp_hit,
    input btb_entry_pkg::target_t resp_target
);

    int unsigned fail_count = 0;    // Failed assertions so far.

    // **************************************************
    // Response handshake.
    // **************************************************

    // One response per sampled read, one cycle later.
    a_valid_follows_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        1'b1 |=> (resp_valid == $past(mem_read))
    ) else begin
        $error("resp_valid does not follow mem_read");
        fail_count++;
    end

    // Nothing pending right after reset.
    a_valid_low_after_reset: assert property (
        @(posedge clk)
        $rose(rst_n) |-> !resp_valid
    ) else begin
        $error("resp_valid high after reset");
        fail_count++;
    end

    // A hit only comes with a response.
    a_hit_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_hit |-> resp_valid
    ) else begin
        $error("resp_hit without resp_valid");
        fail_count++;
    end

    // Target held until the next read loads it.
    a_target_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (resp_valid && !mem_read) |=> $stable(resp_target)
    ) else begin
        $error("resp_target changed without a read");
        fail_count++;
    end

endmodule

bind btb_top btb_assert u_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_read    (mem_read),
    .resp_valid  (resp_valid),
    .resp_hit    (resp_hit),
    .resp_target (resp_target)
);

`default_nettype wire

// File: test/tb_btb.sv
`timescale 1ns/1ps
`default_nettype none

`include "btb_cfg.svh"

module tb_btb;

    import btb_addr_pkg::*;
    import btb_entry_pkg::*;

    localparam int RESP_TIMEOUT  = 20;    // Cycles to wait for resp_valid.
    localparam int RESET_TIMEOUT = 20;    // Cycles to wait for rst_n.
    localparam int NUM_TARGETS   = 11;

    // One table row without its name.
    typedef struct packed {
        logic    rd;
        logic    wr;
        pc_t     pc;
        target_t tgt;
        logic    exp_hit;
        target_t exp_tgt;
    } row_t;

    logic    clk;
    logic    rst_n;
    logic    mem_read;
    logic    mem_write;
    pc_t     pc;
    target_t wr_target;
    logic    resp_valid;
    logic    resp_hit;
    target_t resp_target;

    row_t    rows [$];                 // Stimulus table.
    string   row_name [$];             // Names, same order.
    target_t tgt [NUM_TARGETS];        // Random branch targets.
    integer  seed;
    int      waited;

    tb_clk_gen #(.PERIOD(4.0)) u_clk_gen (.clk(clk), .rst_n(rst_n));

    btb_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .pc          (pc),
        .wr_target   (wr_target),
        .resp_valid  (resp_valid),
        .resp_hit    (resp_hit),
        .resp_target (resp_target)
    );

    // PC from tag and set, offset zero.
    function automatic pc_t make_pc(input tag_t tag, input index_t idx);
        return {tag, idx, {`BTB_S_OFFSET{1'b0}}};
    endfunction

    task automatic add_row(input string name, input logic rd, input logic wr, input pc_t a,
                           input target_t t, input logic eh, input target_t et);
        row_t r;
        r = '{rd: rd, wr: wr, pc: a, tgt: t, exp_hit: eh, exp_tgt: et};
        rows.push_back(r);
        row_name.push_back(name);
    endtask

    task automatic check_hit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s: hit expected %0b, actual %0b", name, exp, act);
            $display("Test failed");
            $fatal(1, "hit check");
        end
    endtask

    task automatic check_target(input string name, input target_t exp, input target_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: target expected %h, actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1, "target check");
        end
    endtask

    // **************************************************
    // Table. Miss rows expect a zero target.
    // **************************************************
    task automatic build_table();
        add_row("rd_empty_set0", 1, 0, make_pc(27'h01, 3'd0), '0, 0, '0);
        add_row("rd_empty_set5", 1, 0, make_pc(27'h55, 3'd5), '0, 0, '0);
        add_row("wr_a_set1", 0, 1, make_pc(27'h10, 3'd1), tgt[0], 0, '0);
        add_row("rd_a_set1", 1, 0, make_pc(27'h10, 3'd1), '0, 1, tgt[0]);
        add_row("rd_alias_set1", 1, 0, make_pc(27'h11, 3'd1), '0, 0, '0);
        add_row("wr_x_set2", 0, 1, make_pc(27'h20, 3'd2), tgt[1], 0, '0);
        add_row("wr_y_set2", 0, 1, make_pc(27'h21, 3'd2), tgt[2], 0, '0);
        add_row("rd_x_set2", 1, 0, make_pc(27'h20, 3'd2), '0, 1, tgt[1]);
        add_row("rd_y_set2", 1, 0, make_pc(27'h21, 3'd2), '0, 1, tgt[2]);
        add_row("wr_z_set2", 0, 1, make_pc(27'h22, 3'd2), tgt[3], 0, '0);   // LRU is x.
        add_row("rd_z_set2", 1, 0, make_pc(27'h22, 3'd2), '0, 1, tgt[3]);
        add_row("rd_x_evicted", 1, 0, make_pc(27'h20, 3'd2), '0, 0, '0);
        add_row("rd_y_kept", 1, 0, make_pc(27'h21, 3'd2), '0, 1, tgt[2]);
        add_row("wr_a_set3", 0, 1, make_pc(27'h30, 3'd3), tgt[4], 0, '0);
        add_row("wr_b_set3", 0, 1, make_pc(27'h31, 3'd3), tgt[5], 0, '0);
        add_row("rd_a_set3", 1, 0, make_pc(27'h30, 3'd3), '0, 1, tgt[4]);   // Protects a.
        add_row("wr_c_set3", 0, 1, make_pc(27'h32, 3'd3), tgt[6], 0, '0);
        add_row("rd_b_evicted", 1, 0, make_pc(27'h31, 3'd3), '0, 0, '0);
        add_row("rd_a_survives", 1, 0, make_pc(27'h30, 3'd3), '0, 1, tgt[4]);
        add_row("rd_c_set3", 1, 0, make_pc(27'h32, 3'd3), '0, 1, tgt[6]);
        add_row("wr_p_set4", 0, 1, make_pc(27'h40, 3'd4), tgt[7], 0, '0);
        add_row("wr_q_set4", 0, 1, make_pc(27'h41, 3'd4), tgt[8], 0, '0);
        add_row("wr_q_again", 0, 1, make_pc(27'h41, 3'd4), tgt[9], 0, '0);  // LRU is p.
        add_row("rd_q_new", 1, 0, make_pc(27'h41, 3'd4), '0, 1, tgt[9]);
        add_row("rd_p_kept", 1, 0, make_pc(27'h40, 3'd4), '0, 1, tgt[7]);
        add_row("rdwr_r_set6", 1, 1, make_pc(27'h60, 3'd6), tgt[10], 0, '0); // Old contents.
        add_row("rd_r_set6", 1, 0, make_pc(27'h60, 3'd6), '0, 1, tgt[10]);
    endtask

    // One request on a falling edge, then the check if it reads.
    task automatic apply_row(input int i);
        row_t r;
        int   cnt;
        r = rows[i];
        @(negedge clk);
        mem_read  = r.rd;
        mem_write = r.wr;
        pc        = r.pc;
        wr_target = r.tgt;
        @(negedge clk);
        mem_read  = 1'b0;
        mem_write = 1'b0;
        if (r.rd) begin
            cnt = 0;
            while (!resp_valid && cnt < RESP_TIMEOUT) begin
                @(negedge clk);
                cnt++;
            end
            if (!resp_valid) begin
                $display("Response never arrived for %s", row_name[i]);
                $display("Test failed");
                $fatal(1, "response timeout");
            end
            check_hit(row_name[i], r.exp_hit, resp_hit);
            check_target(row_name[i], r.exp_tgt, resp_target);
        end
    endtask

    // **************************************************
    // Main sequence.
    // **************************************************
    initial begin
        mem_read  = 1'b0;
        mem_write = 1'b0;
        pc        = '0;
        wr_target = '0;
        seed      = 32'hc47459be;
        for (int k = 0; k < NUM_TARGETS; k++) begin
            tgt[k] = $random(seed);
        end
        build_table();

        waited = 0;
        while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was never released");
            $display("Test failed");
            $fatal(1, "reset timeout");
        end

        for (int i = 0; i < rows.size(); i++) begin
            apply_row(i);
        end

        if (dut.u_assert.fail_count != 0) begin
            $display("Bound assertions failed %0d times", dut.u_assert.fail_count);
            $display("Test failed");
            $fatal(1, "assertion failure");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+common
common/btb_addr_pkg.sv
common/btb_entry_pkg.sv
common/btb_ctrl_if.sv
hw/btb_control.sv
hw/btb_datapath/btb_datapath.sv
hw/btb_top.sv
test/tb_clk_gen.sv
test/btb_assert.sv
test/tb_btb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_btb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Test failed
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
